/* burst_write_pkg.sv */
package burst_write_pkg;

    // ==========================================================
    // bus defaults
    // ==========================================================

    // top level DATA_W falls back to this
    localparam int data_w_default = 32;

    // byte address and byte length widths of the command port
    localparam int addr_w_default = 32;
    localparam int len_w_default  = 12;

    // ==========================================================
    // width helpers
    // ==========================================================

    // number of address bits that select a byte inside one bus word
    function automatic int offset_width(input int data_w);
        int bytes;
        int width;
        bytes = data_w / 8;
        width = 0;
        while ((1 << width) < bytes) begin
            width = width + 1;
        end
        return width;
    endfunction

    // one strobe bit per byte lane
    function automatic int strb_width(input int data_w);
        return data_w / 8;
    endfunction

endpackage

/* burst_split.sv */
`timescale 1ns/1ps

module burst_split #(
    parameter int DATA_W = burst_write_pkg::data_w_default,
    localparam int OFFSET_W = burst_write_pkg::offset_width(DATA_W)
) (
    input  logic                clk,
    input  logic                rst,
    input  logic [OFFSET_W-1:0] offset,
    input  logic [DATA_W-1:0]   data_in,
    input  logic                data_valid,
    output logic [DATA_W-1:0]   data_out
);

    localparam int STORE_W = DATA_W - 8;
    localparam int JOIN_W  = DATA_W + STORE_W;

    logic [STORE_W-1:0]    stored_data;  // upper bytes of the previous word
    logic [JOIN_W-1:0]     joined;
    logic [OFFSET_W+3:0]   shift_bits;   // wide enough to index all of joined

    // ==========================================================
    // previous word
    // ==========================================================

    // byte 0 of a word always lands in the current beat, so only the
    // upper bytes can spill into the next one
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            stored_data <= '0;
        end else if (data_valid) begin
            stored_data <= data_in[DATA_W-1:8];
        end
    end

    // ==========================================================
    // stitch and rotate
    // ==========================================================

    assign joined = {data_in, stored_data};

    // (bytes - 1 - offset) is the bitwise inverse of the offset
    assign shift_bits = {1'b0, ~offset, 3'b000};

    // offset zero selects data_in unchanged
    assign data_out = joined[shift_bits +: DATA_W];

endmodule

/* burst_strobe_gen.sv */
`timescale 1ns/1ps

module burst_strobe_gen #(
    parameter int DATA_W = burst_write_pkg::data_w_default,
    localparam int OFFSET_W = burst_write_pkg::offset_width(DATA_W),
    localparam int STRB_W   = burst_write_pkg::strb_width(DATA_W)
) (
    input  logic [OFFSET_W-1:0] offset,
    input  logic [OFFSET_W-1:0] end_byte,
    input  logic                first,
    input  logic                last,
    output logic [STRB_W-1:0]   strb
);

    logic [STRB_W-1:0] low_mask;   // lanes at or above the start offset
    logic [STRB_W-1:0] high_mask;  // lanes at or below the final byte

    // ==========================================================
    // lane masks
    // ==========================================================

    always_comb begin
        for (int i = 0; i < STRB_W; i++) begin
            low_mask[i]  = (OFFSET_W'(i) >= offset);
            high_mask[i] = (OFFSET_W'(i) <= end_byte);
        end
    end

    // a single-beat burst applies both masks at once
    always_comb begin
        strb = '1;
        if (first) begin
            strb = strb & low_mask;
        end
        if (last) begin
            strb = strb & high_mask;
        end
    end

endmodule

/* burst_write_ctrl.sv */
`timescale 1ns/1ps

module burst_write_ctrl #(
    parameter int DATA_W = burst_write_pkg::data_w_default,
    parameter int ADDR_W = burst_write_pkg::addr_w_default,
    parameter int LEN_W  = burst_write_pkg::len_w_default,
    localparam int OFFSET_W = burst_write_pkg::offset_width(DATA_W)
) (
    input  logic                clk,
    input  logic                rst,

    input  logic                cmd_req,
    input  logic [ADDR_W-1:0]   cmd_addr,
    input  logic [LEN_W-1:0]    cmd_len,
    output logic                cmd_ack,

    input  logic [DATA_W-1:0]   src_data,
    input  logic                src_valid,
    output logic                src_ready,

    input  logic                out_ready,
    output logic                out_valid,
    output logic                out_last,

    output logic [DATA_W-1:0]   split_word,
    output logic                split_advance,
    output logic [OFFSET_W-1:0] offset,
    output logic [OFFSET_W-1:0] end_byte,
    output logic                first
);

    localparam int BYTES = burst_write_pkg::strb_width(DATA_W);
    localparam int CNT_W = LEN_W + 2;  // room for the offset and the round-up

    localparam logic [1:0] ST_IDLE   = 2'd0;
    localparam logic [1:0] ST_STREAM = 2'd1;
    localparam logic [1:0] ST_FLUSH  = 2'd2;
    localparam logic [1:0] ST_ACK    = 2'd3;

    logic [1:0]          state;
    logic [CNT_W-1:0]    words_left;   // source words still to consume
    logic [CNT_W-1:0]    beats_left;   // output beats still to send
    logic                first_q;
    logic [OFFSET_W-1:0] offset_q;
    logic [OFFSET_W-1:0] end_q;

    logic                accept;
    logic                beat_fire;
    logic [CNT_W-1:0]    words_init;
    logic [CNT_W-1:0]    beats_init;
    logic [OFFSET_W-1:0] addr_offset;
    logic [OFFSET_W-1:0] end_init;

    // ==========================================================
    // command decode
    // ==========================================================

    assign addr_offset = cmd_addr[OFFSET_W-1:0];
    assign accept      = (state == ST_IDLE) && cmd_req && !cmd_ack;

    assign words_init = (CNT_W'(cmd_len) + CNT_W'(BYTES - 1)) >> OFFSET_W;
    assign beats_init = (CNT_W'(cmd_len) + CNT_W'(addr_offset) + CNT_W'(BYTES - 1)) >> OFFSET_W;

    // lane of the final payload byte within the last beat
    assign end_init = addr_offset + cmd_len[OFFSET_W-1:0] - OFFSET_W'(1);

    always_ff @(posedge clk) begin
        if (accept) begin
            offset_q <= addr_offset;
            end_q    <= end_init;
        end
    end

    // ==========================================================
    // sequencer
    // ==========================================================

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= ST_IDLE;
            words_left <= '0;
            beats_left <= '0;
            first_q    <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (accept) begin
                        words_left <= words_init;
                        beats_left <= beats_init;
                        first_q    <= 1'b1;
                        state      <= (cmd_len == '0) ? ST_ACK : ST_STREAM;
                    end
                end
                ST_STREAM: begin
                    if (beat_fire) begin
                        first_q    <= 1'b0;
                        words_left <= words_left - CNT_W'(1);
                        beats_left <= beats_left - CNT_W'(1);
                        if (words_left == CNT_W'(1)) begin
                            // one beat more than words means the tail spilled over
                            state <= (beats_left == CNT_W'(1)) ? ST_ACK : ST_FLUSH;
                        end
                    end
                end
                ST_FLUSH: begin
                    if (beat_fire) begin
                        beats_left <= beats_left - CNT_W'(1);
                        state      <= ST_ACK;
                    end
                end
                default: begin
                    if (!cmd_req) begin
                        state <= ST_IDLE;  // ack drops one cycle after req
                    end
                end
            endcase
        end
    end

    // ==========================================================
    // beat outputs
    // ==========================================================

    always_comb begin
        out_valid  = 1'b0;
        src_ready  = 1'b0;
        out_last   = 1'b0;
        split_word = '0;
        case (state)
            ST_STREAM: begin
                out_valid  = src_valid;
                src_ready  = out_ready;
                out_last   = (beats_left == CNT_W'(1));
                split_word = src_data;
            end
            ST_FLUSH: begin
                out_valid = 1'b1;  // zero word pushes out the stored bytes
                out_last  = 1'b1;
            end
            default: begin
            end
        endcase
    end

    assign beat_fire     = out_valid && out_ready;
    assign split_advance = beat_fire;
    assign cmd_ack       = (state == ST_ACK);
    assign first         = first_q;
    assign offset        = offset_q;
    assign end_byte      = end_q;

endmodule

/* burst_write_top.sv */
`timescale 1ns/1ps

module burst_write_top #(
    parameter int DATA_W = burst_write_pkg::data_w_default,
    parameter int ADDR_W = burst_write_pkg::addr_w_default,
    parameter int LEN_W  = burst_write_pkg::len_w_default,
    localparam int STRB_W = burst_write_pkg::strb_width(DATA_W)
) (
    input  logic              clk,
    input  logic              rst,

    input  logic              cmd_req,
    input  logic [ADDR_W-1:0] cmd_addr,
    input  logic [LEN_W-1:0]  cmd_len,
    output logic              cmd_ack,

    input  logic [DATA_W-1:0] src_data,
    input  logic              src_valid,
    output logic              src_ready,

    output logic [DATA_W-1:0] out_data,
    output logic [STRB_W-1:0] out_strb,
    output logic              out_last,
    output logic              out_valid,
    input  logic              out_ready
);

    localparam int OFFSET_W = burst_write_pkg::offset_width(DATA_W);

    logic [DATA_W-1:0]   split_word;
    logic                split_advance;
    logic [OFFSET_W-1:0] offset;
    logic [OFFSET_W-1:0] end_byte;
    logic                first;

    // ==========================================================
    // sequencer
    // ==========================================================

    burst_write_ctrl #(
        .DATA_W (DATA_W),
        .ADDR_W (ADDR_W),
        .LEN_W  (LEN_W)
    ) burst_write_ctrl_i (
        .clk           (clk),
        .rst           (rst),
        .cmd_req       (cmd_req),
        .cmd_addr      (cmd_addr),
        .cmd_len       (cmd_len),
        .cmd_ack       (cmd_ack),
        .src_data      (src_data),
        .src_valid     (src_valid),
        .src_ready     (src_ready),
        .out_ready     (out_ready),
        .out_valid     (out_valid),
        .out_last      (out_last),
        .split_word    (split_word),
        .split_advance (split_advance),
        .offset        (offset),
        .end_byte      (end_byte),
        .first         (first)
    );

    // ==========================================================
    // data and strobe path
    // ==========================================================

    burst_split #(
        .DATA_W (DATA_W)
    ) burst_split_i (
        .clk        (clk),
        .rst        (rst),
        .offset     (offset),
        .data_in    (split_word),
        .data_valid (split_advance),
        .data_out   (out_data)
    );

    burst_strobe_gen #(
        .DATA_W (DATA_W)
    ) burst_strobe_gen_i (
        .offset   (offset),
        .end_byte (end_byte),
        .first    (first),
        .last     (out_last),
        .strb     (out_strb)
    );

endmodule

/* burst_write_checker.sv */
`timescale 1ns/1ps

module burst_write_checker #(
    parameter int DATA_W = burst_write_pkg::data_w_default,
    localparam int STRB_W = burst_write_pkg::strb_width(DATA_W)
) (
    input logic              clk,
    input logic              rst,
    input logic              cmd_req,
    input logic              cmd_ack,
    input logic              src_valid,
    input logic              src_ready,
    input logic [DATA_W-1:0] out_data,
    input logic [STRB_W-1:0] out_strb,
    input logic              out_last,
    input logic              out_valid,
    input logic              out_ready
);

    // a stalled beat keeps its data, strobes and last flag
    stall_hold: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_strb)
            && $stable(out_last))
        else $error("beat outputs changed while out_ready was low");

    ack_needs_req: assert property (@(posedge clk) disable iff (rst)
        $rose(cmd_ack) |-> cmd_req)
        else $error("cmd_ack rose while cmd_req was low");

    // a beat with no source word offered can only be the flush beat
    flush_no_src: assert property (@(posedge clk) disable iff (rst)
        out_valid && !src_valid |-> !src_ready)
        else $error("src_ready high during the flush beat");

    quiet_after_reset: assert property (@(posedge clk)
        $fell(rst) |-> !out_valid && !src_ready && !cmd_ack && !out_last)
        else $error("outputs active right after reset");

endmodule

bind burst_write_top burst_write_checker #(
    .DATA_W (DATA_W)
) burst_write_checker_i (
    .clk       (clk),
    .rst       (rst),
    .cmd_req   (cmd_req),
    .cmd_ack   (cmd_ack),
    .src_valid (src_valid),
    .src_ready (src_ready),
    .out_data  (out_data),
    .out_strb  (out_strb),
    .out_last  (out_last),
    .out_valid (out_valid),
    .out_ready (out_ready)
);

/* tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;  // 20 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        #1 rst = 1'b0;  // released just after the second edge
    end

endmodule

/* burst_write_tb.sv */
`timescale 1ns/1ps

module burst_write_tb;

    localparam int DATA_W       = 32;
    localparam int ADDR_W       = burst_write_pkg::addr_w_default;
    localparam int LEN_W        = burst_write_pkg::len_w_default;
    localparam int STRB_W       = burst_write_pkg::strb_width(DATA_W);
    localparam int GOLDEN_DEPTH = 256;

    logic              clk;
    logic              rst;
    logic              cmd_req;
    logic [ADDR_W-1:0] cmd_addr;
    logic [LEN_W-1:0]  cmd_len;
    logic              cmd_ack;
    logic [DATA_W-1:0] src_data;
    logic              src_valid;
    logic              src_ready;
    logic [DATA_W-1:0] out_data;
    logic [STRB_W-1:0] out_strb;
    logic              out_last;
    logic              out_valid;
    logic              out_ready;

    logic [31:0] golden [0:GOLDEN_DEPTH-1];
    integer      seed = 32'hdb54_ac13;
    int          error_count = 0;
    int          check_count = 0;
    int          cycle_count = 0;
    int          timeout_limit = 0;

    tb_clock_gen tb_clock_gen_i (
        .clk (clk),
        .rst (rst)
    );

    burst_write_top #(
        .DATA_W (DATA_W),
        .ADDR_W (ADDR_W),
        .LEN_W  (LEN_W)
    ) burst_write_top_i (
        .clk       (clk),
        .rst       (rst),
        .cmd_req   (cmd_req),
        .cmd_addr  (cmd_addr),
        .cmd_len   (cmd_len),
        .cmd_ack   (cmd_ack),
        .src_data  (src_data),
        .src_valid (src_valid),
        .src_ready (src_ready),
        .out_data  (out_data),
        .out_strb  (out_strb),
        .out_last  (out_last),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    // ==========================================================
    // checking helpers
    // ==========================================================

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected, input logic [31:0] mask);
        check_count++;
        if ((actual & mask) !== (expected & mask)) begin
            error_count++;
            $display("[ERROR] %s: got %h, expected %h", name, actual & mask, expected & mask);
        end
    endtask

    // disabled lanes carry no defined data
    function automatic logic [31:0] lane_mask(input logic [31:0] strb);
        logic [31:0] mask;
        mask = '0;
        for (int i = 0; i < STRB_W; i++) begin
            if (strb[i]) begin
                mask[8*i +: 8] = 8'hff;
            end
        end
        return mask;
    endfunction

    task automatic check_beat(input int idx, input int cmd_index, input int beat_index);
        string where;
        where = $sformatf("(cmd %0d beat %0d)", cmd_index, beat_index);
        check_value({"out_data ", where}, out_data, golden[idx], lane_mask(golden[idx+1]));
        check_value({"out_strb ", where}, 32'(out_strb), golden[idx+1], '1);
        check_value({"out_last ", where}, 32'(out_last), golden[idx+2], '1);
    endtask

    // ==========================================================
    // one command with its source words and beats
    // ==========================================================

    task automatic run_command(input int cmd_index, inout int pos);
        logic [31:0] addr;
        logic [31:0] len;
        int          n_words;
        int          n_beats;
        int          word_base;
        int          beat_base;
        int          word_idx;
        int          beat_idx;
        bit          done;
        addr      = golden[pos];
        len       = golden[pos+1];
        n_words   = int'(golden[pos+2]);
        n_beats   = int'(golden[pos+3]);
        word_base = pos + 4;
        beat_base = word_base + n_words;
        pos       = beat_base + 3 * n_beats;
        word_idx  = 0;
        beat_idx  = 0;
        done      = 1'b0;
        cmd_req   = 1'b1;
        cmd_addr  = addr[ADDR_W-1:0];
        cmd_len   = len[LEN_W-1:0];
        while (!done) begin
            src_valid = (word_idx < n_words);
            src_data  = src_valid ? golden[word_base+word_idx] : '0;
            out_ready = (($random(seed) & 3) != 0);  // stall about one cycle in four
            @(negedge clk);
            if (cmd_ack) begin
                check_value("beats before cmd_ack", 32'(beat_idx), 32'(n_beats), '1);
                check_value("words consumed", 32'(word_idx), 32'(n_words), '1);
                done = 1'b1;
            end else begin
                // a beat built from a source word passes out_ready back to the source
                if (out_valid && src_valid) begin
                    check_value("src_ready", 32'(src_ready), 32'(out_ready), '1);
                end
                if (src_valid && src_ready) begin
                    word_idx++;
                end
                if (out_valid && out_ready) begin
                    if (beat_idx < n_beats) begin
                        check_beat(beat_base + 3 * beat_idx, cmd_index, beat_idx);
                    end else begin
                        error_count++;
                        $display("command %0d: DUT sent a beat past the expected count",
                                 cmd_index);
                    end
                    beat_idx++;
                end
            end
            @(posedge clk);
            #1;
        end
        cmd_req   = 1'b0;
        src_valid = 1'b0;
        out_ready = 1'b0;
        @(negedge clk);
        check_value("cmd_ack held", 32'(cmd_ack), 32'd1, '1);
        @(negedge clk);
        check_value("cmd_ack released", 32'(cmd_ack), 32'd0, '1);
        @(posedge clk);
        #1;
    endtask

    // ==========================================================
    // main sequence
    // ==========================================================

    initial begin
        int pos;
        int cmd_total;
        int beat_total;
        cmd_req   = 1'b0;
        cmd_addr  = '0;
        cmd_len   = '0;
        src_data  = '0;
        src_valid = 1'b0;
        out_ready = 1'b0;
        $readmemh("burst_write_golden.txt", golden);
        cmd_total  = int'(golden[0]);
        beat_total = 0;
        pos        = 1;
        for (int c = 0; c < cmd_total; c++) begin
            beat_total += int'(golden[pos+3]);
            pos += 4 + int'(golden[pos+2]) + 3 * int'(golden[pos+3]);
        end
        timeout_limit = beat_total * 8 + cmd_total * 20;
        if (cmd_total <= 0) begin
            error_count++;
            $display("golden file holds no commands");
        end
        repeat (4) begin
            @(negedge clk);
            check_value("out_valid", 32'(out_valid), 32'd0, '1);
            check_value("src_ready", 32'(src_ready), 32'd0, '1);
            check_value("cmd_ack", 32'(cmd_ack), 32'd0, '1);
        end
        @(posedge clk);
        #1;
        pos = 1;
        for (int c = 0; c < cmd_total; c++) begin
            run_command(c, pos);
        end
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (timeout_limit > 0 && cycle_count >= timeout_limit) begin
            $display("run timed out after %0d cycles without finishing", cycle_count);
            $display("checks: %0d, errors: %0d", check_count, error_count);
            $display("** FAIL **");
            $finish;
        end
    end

endmodule

/* burst_write_golden.txt */
// first value: command count; per command: addr len words beats, then the source words,
// then one line per beat: data strb last (data is zero in lanes whose strobe is clear)
6
// aligned, two words
00000100 00000008 00000002 00000002
03020100 07060504
03020100 0000000f 00000000
07060504 0000000f 00000001
// offset 3, six bytes, flush beat
00000203 00000006 00000002 00000003
13121110 eeee1514
10000000 00000008 00000000
14131211 0000000f 00000000
00000015 00000001 00000001
// offset 1, two bytes inside one word
00000301 00000002 00000001 00000001
dddd2120
00212000 00000006 00000001
// zero length
00000400 00000000 00000000 00000000
// offset 2, eleven bytes, flush beat
00000502 0000000b 00000003 00000004
33323130 37363534 cc3a3938
31300000 0000000c 00000000
35343332 0000000f 00000000
39383736 0000000f 00000000
0000003a 00000001 00000001
// offset 1, seven bytes, no flush
00000601 00000007 00000002 00000002
43424140 bb464544
42414000 0000000e 00000000
46454443 0000000f 00000001

/* burst_write.f */
burst_write_pkg.sv
burst_split.sv
burst_strobe_gen.sv
burst_write_ctrl.sv
burst_write_top.sv
burst_write_checker.sv
tb_clock_gen.sv
burst_write_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds the burst write testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f burst_write.f \
    --top-module burst_write_tb -o burst_write_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/burst_write_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q -x -F '** PASS **'; then
    exit 0
fi
exit 1
